// File: dv/console_periph_asserts.sv
`timescale 1ns/1ps

module console_periph_asserts import irq_pkg::*; (
   input logic                 sys_clk,
   input logic                 arst_n,
   input logic                 cpu_interrupt,
   input logic [irq_id_w-1:0]  cpu_interrupt_id,
   input logic                 ack_interrupt,
   input logic [irq_id_w-1:0]  ack_interrupt_id,
   input logic                 data_latch,
   input logic                 data_clock,
   input logic [irq_lines-1:0] irq_vec
);

   int fail_count = 0;   // Read by the testbench at the end

   irq_low_in_reset: assert property (@(posedge sys_clk) !arst_n |-> !cpu_interrupt)
      else begin
         fail_count++;
         $error("cpu_interrupt high during reset");
      end

   // Pad strobes are strictly sequential
   latch_clock_apart: assert property (@(posedge sys_clk) disable iff (!arst_n)
      !(data_latch && data_clock))
      else begin
         fail_count++;
         $error("data_latch and data_clock high together");
      end

   ack_clears_id: assert property (@(posedge sys_clk) disable iff (!arst_n)
      (ack_interrupt && !irq_vec[ack_interrupt_id])
      |=> !(cpu_interrupt && cpu_interrupt_id == $past(ack_interrupt_id)))
      else begin
         fail_count++;
         $error("acknowledged id still presented");
      end

endmodule

bind console_periph console_periph_asserts u_asserts (
   .sys_clk          (sys_clk),
   .arst_n           (arst_n),
   .cpu_interrupt    (cpu_interrupt),
   .cpu_interrupt_id (cpu_interrupt_id),
   .ack_interrupt    (ack_interrupt),
   .ack_interrupt_id (ack_interrupt_id),
   .data_latch       (data_latch),
   .data_clock       (data_clock),
   .irq_vec          (irq_vec)
);

// File: dv/tb_console_periph.sv
`timescale 1ns/1ps

module tb_console_periph
   import console_map_pkg::*, irq_pkg::*;
();

   localparam int clk_period  = 100;
   localparam int scan_cycles = 34 * 4;   // Latch, gap, 16 clock pulses at half period 4

   typedef enum logic [2:0] {
      op_write, op_read, op_peek, op_wait_irq, op_ack, op_set_pad, op_quiet, op_prng
   } op_t;

   // wait_irq uses addr as latency reference, data as min and lim as max latency
   typedef struct packed {
      op_t         op;
      logic [2:0]  tid;
      logic [15:0] addr;
      logic [15:0] data;
      logic [15:0] exp_val;
      logic [15:0] lim;
   } row_t;

   logic                sys_clk;
   logic                arst_n;
   logic [7:0]          sw;
   logic [4:0]          btn;
   logic                serial_data;
   logic [addr_w-1:0]   mem_addr;
   logic                mem_rd_en;
   logic                mem_wr_en;
   logic [data_w-1:0]   mem_wr_data;
   logic                ack_interrupt;
   logic [irq_id_w-1:0] ack_interrupt_id;
   logic [data_w-1:0]   mem_rd_data;
   logic                cpu_interrupt;
   logic [irq_id_w-1:0] cpu_interrupt_id;
   logic                data_latch;
   logic                data_clock;
   logic [7:0]          led;
   logic [data_w-1:0]   seg_hex;

   row_t        rows[$];
   string       test_names [0:5];
   time         wr_stamp [logic [15:0]];   // Half a cycle after each write edge
   logic        table_ready = 1'b0;
   integer      seed = 32'hfa6d;
   int          errors = 0;
   int          test_errors = 0;
   int          checks = 0;
   logic [15:0] pad_pattern = '0;
   logic [15:0] pad_shift = '0;

   console_periph #(.tick_div(20), .pad_half_period(4)) u_dut (.*);

   initial begin
      sys_clk = 1'b0;
      forever #(clk_period / 2) sys_clk = ~sys_clk;
   end

   ////////////////////////////////////////////////////////////
   // Game-pad model
   ////////////////////////////////////////////////////////////
   assign serial_data = ~pad_shift[0];   // Pressed buttons pull the line low

   always @(posedge data_latch or posedge data_clock) begin
      if (data_latch) pad_shift <= pad_pattern;
      else pad_shift <= {1'b0, pad_shift[15:1]};
   end

   task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string what);
      checks++;
      if (got !== want) begin
         $display("[FAIL] %0d ns: %s: got %0h, expected %0h", $time, what, got, want);
         errors++;
         test_errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // CPU side bus tasks
   ////////////////////////////////////////////////////////////
   task automatic bus_write(input logic [15:0] addr, input logic [15:0] data);
      @(negedge sys_clk);
      mem_addr    = addr;
      mem_wr_data = data;
      mem_wr_en   = 1'b1;
      @(negedge sys_clk);
      mem_wr_en      = 1'b0;
      wr_stamp[addr] = $time;
   endtask

   task automatic bus_read(input logic [15:0] addr, output logic [15:0] data);
      @(negedge sys_clk);
      mem_addr  = addr;
      mem_rd_en = 1'b1;
      @(negedge sys_clk);
      mem_rd_en = 1'b0;
      @(negedge sys_clk);   // Past edge N+1
      data = mem_rd_data;
   endtask

   task automatic wait_irq(input row_t r);
      time t0;
      int  waited;
      int  lat;
      t0     = wr_stamp.exists(r.addr) ? wr_stamp[r.addr] : $time;
      waited = 0;
      while (!cpu_interrupt && waited <= r.lim + 10) begin
         @(negedge sys_clk);
         waited++;
      end
      if (!cpu_interrupt) begin
         $display("Error at %0d ns: interrupt id %0d never arrived", $time, r.exp_val);
         errors++;
         test_errors++;
      end else begin
         lat = int'(($time - t0) / clk_period);
         check_eq(cpu_interrupt_id, r.exp_val, "presented interrupt id");
         check_eq(lat >= r.data && lat <= r.lim, 1,
                  $sformatf("latency %0d cycles outside %0d..%0d", lat, r.data, r.lim));
      end
   endtask

   task automatic add_row(input op_t op, input logic [2:0] tid, input logic [15:0] addr,
                          input logic [15:0] data, input logic [15:0] exp_val,
                          input logic [15:0] lim);
      rows.push_back('{op, tid, addr, data, exp_val, lim});
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////////////////////////
   task automatic build_table();
      logic [15:0] ram_addr [0:3];
      logic [15:0] word [0:3];
      ram_addr = '{16'h0000, 16'h0123, 16'h1FFF, 16'h3FFF};
      test_names = '{"RAM and read mux", "LED and hex display", "interval timers",
                     "software interrupts", "game-pad reader", "random source"};
      for (int i = 0; i < 4; i++) begin
         word[i] = 16'($random(seed));
         add_row(op_write, 0, ram_addr[i], word[i], 0, 0);
      end
      for (int i = 0; i < 4; i++) add_row(op_read, 0, ram_addr[i], 0, word[i], 0);
      add_row(op_read, 0, sw_addr, 0, 16'hA513, 0);   // sw A5, btn 13
      add_row(op_read, 0, 16'h4010, 0, 16'hDEAF, 0);
      add_row(op_read, 0, 16'hC000, 0, 16'hDEAF, 0);
      add_row(op_write, 1, led_addr, 16'h1234, 0, 0);
      add_row(op_peek, 1, led_addr, 0, 16'h0034, 0);
      add_row(op_write, 1, seg_addr, 16'hBEEF, 0, 0);
      add_row(op_peek, 1, seg_addr, 0, 16'hBEEF, 0);
      // Windows of (n-1)*20 to n*20+2 cycles
      add_row(op_write, 2, timer0_addr, 2, 0, 0);
      add_row(op_write, 2, timer1_addr, 3, 0, 0);
      add_row(op_wait_irq, 2, timer0_addr, 20, irq_timer0, 42);
      add_row(op_ack, 2, 0, irq_timer0, 0, 0);
      add_row(op_wait_irq, 2, timer1_addr, 40, irq_timer1, 62);
      add_row(op_ack, 2, 0, irq_timer1, 0, 0);
      add_row(op_write, 3, irq_ctrl_addr, 16'h0220, 0, 0);
      add_row(op_wait_irq, 3, irq_ctrl_addr, 0, 5, 4);
      add_row(op_ack, 3, 0, 5, 1, 0);
      add_row(op_wait_irq, 3, irq_ctrl_addr, 0, 9, 20);
      add_row(op_ack, 3, 0, 9, 0, 0);
      add_row(op_set_pad, 4, 0, 16'h8421, 0, 0);
      add_row(op_wait_irq, 4, pad_addr, 0, irq_pad, 2 * scan_cycles + 4);
      add_row(op_read, 4, pad_addr, 0, 16'h8421, 0);
      add_row(op_ack, 4, 0, irq_pad, 0, 0);
      add_row(op_quiet, 4, 0, 0, 0, 2 * scan_cycles);
      add_row(op_prng, 5, prng_addr, 0, 0, 5);
   endtask

   task automatic report_test(input int tid);
      if (test_errors == 0) $display("Test %0d (%s): ok", tid, test_names[tid]);
      else $display("Test %0d (%s): %0d mismatches", tid, test_names[tid], test_errors);
      test_errors = 0;
   endtask

   initial begin
      row_t        r;
      logic [15:0] rd;
      logic [15:0] rd2;
      int          cur_tid;
      arst_n           = 1'b0;
      sw               = 8'hA5;
      btn              = 5'h13;
      mem_addr         = '0;
      mem_rd_en        = 1'b0;
      mem_wr_en        = 1'b0;
      mem_wr_data      = '0;
      ack_interrupt    = 1'b0;
      ack_interrupt_id = '0;
      build_table();
      table_ready = 1'b1;
      repeat (10) @(negedge sys_clk);
      arst_n  = 1'b1;
      cur_tid = rows[0].tid;
      foreach (rows[i]) begin
         r = rows[i];
         if (r.tid != cur_tid) begin
            report_test(cur_tid);
            cur_tid = r.tid;
         end
         case (r.op)
            op_write: bus_write(r.addr, r.data);
            op_read: begin
               bus_read(r.addr, rd);
               check_eq(rd, r.exp_val, $sformatf("read of 0x%04h", r.addr));
            end
            op_peek: begin
               @(negedge sys_clk);
               if (r.addr == led_addr) check_eq({8'h00, led}, r.exp_val, "led output");
               else check_eq(seg_hex, r.exp_val, "seg_hex output");
            end
            op_wait_irq: wait_irq(r);
            op_ack: begin
               @(negedge sys_clk);
               ack_interrupt    = 1'b1;
               ack_interrupt_id = r.data[irq_id_w-1:0];
               @(negedge sys_clk);
               ack_interrupt = 1'b0;
               check_eq(cpu_interrupt, r.exp_val, $sformatf("cpu_interrupt after ack %0d", r.data));
            end
            op_set_pad: begin
               @(negedge sys_clk);
               pad_pattern = r.data;
            end
            op_quiet: begin
               for (int c = 0; c < r.lim; c++) begin
                  @(negedge sys_clk);
                  if (cpu_interrupt) begin
                     check_eq(cpu_interrupt, 0, "interrupt while pad pattern unchanged");
                     break;
                  end
               end
            end
            default: begin
               bus_read(r.addr, rd);
               repeat (r.lim) @(negedge sys_clk);
               bus_read(r.addr, rd2);
               check_eq(rd != 0 && rd2 != 0, 1, "random words nonzero");
               check_eq(rd != rd2, 1, "random words differ");
            end
         endcase
      end
      report_test(cur_tid);
      errors += u_dut.u_asserts.fail_count;
      $display("Checks: %0d run, %0d failed, %0d assertion failures",
               checks, errors, u_dut.u_asserts.fail_count);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   // Watchdog sized from the table
   initial begin
      int budget;
      wait (table_ready);
      budget = 60;
      foreach (rows[i]) budget += rows[i].lim + 20;
      #(budget * clk_period);
      $display("Timed out: run did not finish within %0d cycles", budget);
      $display("Test failures found");
      $finish;
   end

endmodule

// File: filelist.f
logic/console_map_pkg.sv
logic/irq_pkg.sv
logic/bus_decoder.sv
logic/block_ram.sv
logic/interrupt_controller.sv
logic/interval_timer.sv
logic/io_regs.sv
logic/pad_reader.sv
logic/console_periph.sv
dv/console_periph_asserts.sv
dv/tb_console_periph.sv

// File: logic/block_ram.sv
`timescale 1ns/1ps

module block_ram import console_map_pkg::*; (
   input  logic                  sys_clk,
   input  logic                  en,
   input  logic                  wr_en,
   input  logic [ram_addr_w-1:0] addr,
   input  logic [data_w-1:0]     wr_data,
   output logic [data_w-1:0]     rd_data
);

   // 16K words, maps onto block RAM
   logic [data_w-1:0] mem [0:(1 << ram_addr_w) - 1];

   always_ff @(posedge sys_clk) begin
      if (wr_en) begin
         mem[addr] <= wr_data;
      end
      if (en) begin
         rd_data <= mem[addr];   // Read before write
      end
   end

endmodule

// File: logic/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder import console_map_pkg::*; (
   input  logic              sys_clk,
   input  logic              arst_n,
   input  logic [addr_w-1:0] mem_addr,
   input  logic              mem_rd_en,
   input  logic [data_w-1:0] ram_rd_data,
   input  logic [data_w-1:0] prng_data,
   input  logic [data_w-1:0] pad_buttons,
   input  logic [7:0]        sw,
   input  logic [4:0]        btn,
   output logic              ram_sel,
   output logic              irq_sel,
   output logic [1:0]        timer_sel,
   output logic              led_sel,
   output logic              seg_sel,
   output logic [data_w-1:0] mem_rd_data
);

   logic [addr_w-1:0] last_rd_addr;
   logic              last_is_ram;

   ////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////
   // RAM owns every address with the top two bits clear
   assign ram_sel      = (mem_addr[addr_w-1:ram_addr_w] == '0);
   assign irq_sel      = (mem_addr == irq_ctrl_addr);
   assign timer_sel[0] = (mem_addr == timer0_addr);
   assign timer_sel[1] = (mem_addr == timer1_addr);
   assign led_sel      = (mem_addr == led_addr);
   assign seg_sel      = (mem_addr == seg_addr);

   ////////////////////////////////////////////////////////////
   // Read return
   ////////////////////////////////////////////////////////////
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         last_rd_addr <= '1;   // Nothing read yet, points at unmapped space
      end else if (mem_rd_en) begin
         last_rd_addr <= mem_addr;
      end
   end

   assign last_is_ram = (last_rd_addr[addr_w-1:ram_addr_w] == '0);

   always_comb begin
      if (last_is_ram) begin
         mem_rd_data = ram_rd_data;   // RAM data registered on the same edge
      end else begin
         case (last_rd_addr)
            prng_addr: mem_rd_data = prng_data;
            sw_addr:   mem_rd_data = {sw, 3'b000, btn};
            pad_addr:  mem_rd_data = pad_buttons;
            default:   mem_rd_data = unmapped_value;
         endcase
      end
   end

endmodule

// File: logic/console_map_pkg.sv
package console_map_pkg;

   // Bus geometry
   localparam int data_w     = 16;
   localparam int addr_w     = 16;
   localparam int ram_addr_w = 14;   // RAM spans 0x0000 to 0x3FFF

   ////////////////////////////////////////////////////////////
   // Peripheral addresses
   ////////////////////////////////////////////////////////////
   localparam logic [addr_w-1:0] irq_ctrl_addr = 16'h4001;
   localparam logic [addr_w-1:0] prng_addr     = 16'h4002;
   localparam logic [addr_w-1:0] timer0_addr   = 16'h4004;
   localparam logic [addr_w-1:0] timer1_addr   = 16'h4005;
   localparam logic [addr_w-1:0] sw_addr       = 16'h4020;  // Switches and buttons
   localparam logic [addr_w-1:0] led_addr      = 16'h4021;
   localparam logic [addr_w-1:0] seg_addr      = 16'h4022;
   localparam logic [addr_w-1:0] pad_addr      = 16'h4023;

   // Returned for any address nobody claims
   localparam logic [data_w-1:0] unmapped_value = 16'hDEAF;

endpackage

// File: logic/console_periph.sv
`timescale 1ns/1ps

module console_periph import console_map_pkg::*, irq_pkg::*; #(
   parameter int tick_div        = 100000,
   parameter int pad_half_period = 600
) (
   input  logic                sys_clk,
   input  logic                arst_n,
   input  logic [7:0]          sw,
   input  logic [4:0]          btn,
   input  logic                serial_data,
   input  logic [addr_w-1:0]   mem_addr,
   input  logic                mem_rd_en,
   input  logic                mem_wr_en,
   input  logic [data_w-1:0]   mem_wr_data,
   input  logic                ack_interrupt,
   input  logic [irq_id_w-1:0] ack_interrupt_id,
   output logic [data_w-1:0]   mem_rd_data,
   output logic                cpu_interrupt,
   output logic [irq_id_w-1:0] cpu_interrupt_id,
   output logic                data_latch,
   output logic                data_clock,
   output logic [7:0]          led,
   output logic [data_w-1:0]   seg_hex
);

   logic                 ram_sel;
   logic                 irq_sel;
   logic [1:0]           timer_sel;
   logic                 led_sel;
   logic                 seg_sel;
   logic [data_w-1:0]    ram_rd_data;
   logic [data_w-1:0]    prng_data;
   logic [data_w-1:0]    pad_buttons;
   logic                 ms_tick;
   logic [1:0]           timer_wr;
   logic [1:0]           timer_done;
   logic                 pad_change;
   logic [irq_lines-1:0] sw_irq;   // One cycle wide
   logic [irq_lines-1:0] irq_vec;

   ////////////////////////////////////////////////////////////
   // Decode and storage
   ////////////////////////////////////////////////////////////
   bus_decoder u_decoder (
      .sys_clk     (sys_clk),
      .arst_n      (arst_n),
      .mem_addr    (mem_addr),
      .mem_rd_en   (mem_rd_en),
      .ram_rd_data (ram_rd_data),
      .prng_data   (prng_data),
      .pad_buttons (pad_buttons),
      .sw          (sw),
      .btn         (btn),
      .ram_sel     (ram_sel),
      .irq_sel     (irq_sel),
      .timer_sel   (timer_sel),
      .led_sel     (led_sel),
      .seg_sel     (seg_sel),
      .mem_rd_data (mem_rd_data)
   );

   block_ram u_ram (
      .sys_clk (sys_clk),
      .en      (ram_sel & mem_rd_en),   // Hold data until the next read
      .wr_en   (ram_sel & mem_wr_en),
      .addr    (mem_addr[ram_addr_w-1:0]),
      .wr_data (mem_wr_data),
      .rd_data (ram_rd_data)
   );

   io_regs #(.tick_div(tick_div)) u_io (
      .sys_clk   (sys_clk),
      .arst_n    (arst_n),
      .led_wr    (led_sel & mem_wr_en),
      .seg_wr    (seg_sel & mem_wr_en),
      .wr_data   (mem_wr_data),
      .ms_tick   (ms_tick),
      .prng_data (prng_data),
      .led       (led),
      .seg_hex   (seg_hex)
   );

   // Timers share the prescaler tick
   assign timer_wr = timer_sel & {2{mem_wr_en}};

   for (genvar t = 0; t < 2; t++) begin : g_timer
      interval_timer u_timer (
         .sys_clk (sys_clk),
         .arst_n  (arst_n),
         .ms_tick (ms_tick),
         .wr_en   (timer_wr[t]),
         .wr_data (mem_wr_data),
         .done    (timer_done[t])
      );
   end

   pad_reader #(.pad_half_period(pad_half_period)) u_pad (
      .sys_clk     (sys_clk),
      .arst_n      (arst_n),
      .serial_data (serial_data),
      .data_latch  (data_latch),
      .data_clock  (data_clock),
      .buttons     (pad_buttons),
      .pad_change  (pad_change)
   );

   ////////////////////////////////////////////////////////////
   // Interrupt sources
   ////////////////////////////////////////////////////////////
   // Software raise, cleared again the next cycle
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         sw_irq <= '0;
      end else if (irq_sel && mem_wr_en) begin
         sw_irq <= mem_wr_data[irq_lines-1:0];
      end else begin
         sw_irq <= '0;
      end
   end

   always_comb begin
      irq_vec             = sw_irq;
      irq_vec[irq_timer0] = sw_irq[irq_timer0] | timer_done[0];
      irq_vec[irq_timer1] = sw_irq[irq_timer1] | timer_done[1];
      irq_vec[irq_pad]    = sw_irq[irq_pad] | pad_change;
   end

   interrupt_controller u_irq (
      .sys_clk          (sys_clk),
      .arst_n           (arst_n),
      .irq_lines_in     (irq_vec),
      .ack_interrupt    (ack_interrupt),
      .ack_interrupt_id (ack_interrupt_id),
      .cpu_interrupt    (cpu_interrupt),
      .cpu_interrupt_id (cpu_interrupt_id)
   );

endmodule

// File: logic/interrupt_controller.sv
`timescale 1ns/1ps

module interrupt_controller import irq_pkg::*; (
   input  logic                 sys_clk,
   input  logic                 arst_n,
   input  logic [irq_lines-1:0] irq_lines_in,
   input  logic                 ack_interrupt,
   input  logic [irq_id_w-1:0]  ack_interrupt_id,
   output logic                 cpu_interrupt,
   output logic [irq_id_w-1:0]  cpu_interrupt_id
);

   logic [irq_lines-1:0] pending;
   logic [irq_lines-1:0] ack_mask;

   ////////////////////////////////////////////////////////////
   // Pending latches
   ////////////////////////////////////////////////////////////
   // One-hot of the acknowledged id
   assign ack_mask = ack_interrupt ? (irq_lines'(1) << ack_interrupt_id) : '0;

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         pending <= '0;
      end else begin
         // A strobe in the ack cycle keeps its bit set
         pending <= (pending & ~ack_mask) | irq_lines_in;
      end
   end

   ////////////////////////////////////////////////////////////
   // Priority select
   ////////////////////////////////////////////////////////////
   assign cpu_interrupt = |pending;

   // Walk down so the lowest pending id wins
   always_comb begin
      cpu_interrupt_id = '0;
      for (int i = irq_lines - 1; i >= 0; i--) begin
         if (pending[i]) begin
            cpu_interrupt_id = irq_id_w'(i);
         end
      end
   end

endmodule

// File: logic/interval_timer.sv
`timescale 1ns/1ps

module interval_timer (
   input  logic        sys_clk,
   input  logic        arst_n,
   input  logic        ms_tick,
   input  logic        wr_en,
   input  logic [15:0] wr_data,
   output logic        done
);

   logic [15:0] count;   // Milliseconds left

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         if (wr_en) begin
            // Reload, zero parks the timer
            count <= wr_data;
         end else if (ms_tick && (count != '0)) begin
            count <= count - 16'd1;
            done  <= (count == 16'd1);   // Fires on the step into zero
         end
      end
   end

endmodule

// File: logic/io_regs.sv
`timescale 1ns/1ps

module io_regs import console_map_pkg::*; #(
   parameter int tick_div = 100000
) (
   input  logic              sys_clk,
   input  logic              arst_n,
   input  logic              led_wr,
   input  logic              seg_wr,
   input  logic [data_w-1:0] wr_data,
   output logic              ms_tick,
   output logic [data_w-1:0] prng_data,
   output logic [7:0]        led,
   output logic [data_w-1:0] seg_hex
);

   localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;

   logic [cnt_w-1:0]  tick_cnt;
   logic [data_w-1:0] lfsr;
   logic              lfsr_fb;

   ////////////////////////////////////////////////////////////
   // Millisecond prescaler
   ////////////////////////////////////////////////////////////
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         tick_cnt <= '0;
         ms_tick  <= 1'b0;
      end else begin
         ms_tick <= (tick_cnt == cnt_w'(tick_div - 1));
         if (tick_cnt == cnt_w'(tick_div - 1)) begin
            tick_cnt <= '0;
         end else begin
            tick_cnt <= tick_cnt + 1'b1;
         end
      end
   end

   // Taps 16,14,13,11 give the full 2^16-1 sequence
   assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         lfsr    <= 16'hACE1;   // Any nonzero seed
         led     <= '0;
         seg_hex <= '0;
      end else begin
         lfsr <= {lfsr[14:0], lfsr_fb};
         if (led_wr) led <= wr_data[7:0];   // Low byte only
         if (seg_wr) seg_hex <= wr_data;
      end
   end

   assign prng_data = lfsr;

endmodule

// File: logic/irq_pkg.sv
package irq_pkg;

   localparam int irq_lines = 16;
   localparam int irq_id_w  = 4;

   // Fixed ids of the hardware sources
   localparam int irq_timer0 = 0;
   localparam int irq_timer1 = 1;
   // Id 2 stays free for the video frame strobe
   localparam int irq_pad    = 3;

endpackage

// File: logic/pad_reader.sv
`timescale 1ns/1ps

module pad_reader #(
   parameter int pad_half_period = 600
) (
   input  logic        sys_clk,
   input  logic        arst_n,
   input  logic        serial_data,
   output logic        data_latch,
   output logic        data_clock,
   output logic [15:0] buttons,
   output logic        pad_change
);

   localparam int ph_w = (pad_half_period > 1) ? $clog2(pad_half_period) : 1;

   typedef enum logic [2:0] {st_idle, st_latch, st_gap, st_high, st_low} pad_state_t;

   pad_state_t  state;
   logic [ph_w-1:0] phase_cnt;
   logic [3:0]  bit_cnt;
   logic        phase_end;
   logic [15:0] shift_word;   // Pressed = 1 once inverted

   assign phase_end = (phase_cnt == ph_w'(pad_half_period - 1));

   ////////////////////////////////////////////////////////////
   // Scan sequencer
   ////////////////////////////////////////////////////////////
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= st_idle;
         phase_cnt  <= '0;
         bit_cnt    <= '0;
         data_latch <= 1'b0;
         data_clock <= 1'b0;
         buttons    <= '0;
         pad_change <= 1'b0;
      end else begin
         pad_change <= 1'b0;
         phase_cnt  <= phase_end ? '0 : phase_cnt + 1'b1;
         if (phase_end) begin
            case (state)
               st_idle: begin
                  data_latch <= 1'b1;
                  state      <= st_latch;
               end
               st_latch: begin
                  data_latch <= 1'b0;   // Pad now drives button 0
                  state      <= st_gap;
               end
               st_gap, st_low: begin
                  if (state == st_low && bit_cnt == 4'd15) begin
                     // Word complete, commit and relatch
                     buttons    <= shift_word;
                     pad_change <= (shift_word != buttons);
                     bit_cnt    <= '0;
                     data_latch <= 1'b1;
                     state      <= st_latch;
                  end else begin
                     if (state == st_low) bit_cnt <= bit_cnt + 1'b1;
                     data_clock <= 1'b1;   // Sample taken on this rise
                     state      <= st_high;
                  end
               end
               st_high: begin
                  data_clock <= 1'b0;
                  state      <= st_low;
               end
               default: state <= st_idle;
            endcase
         end
      end
   end

   // Active low bits, button 0 arrives first and ends in bit 0
   always_ff @(posedge sys_clk) begin
      if (phase_end && (state == st_gap || (state == st_low && bit_cnt != 4'd15))) begin
         shift_word <= {~serial_data, shift_word[15:1]};
      end
   end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_console_periph \
   -f filelist.f -o tb_console_periph \
   && ./obj_dir/tb_console_periph +verilator+error+limit+1000 \
      | tee /dev/stderr | grep 'All tests passed!' > /dev/null \
   && echo "Simulation PASSED" \
   || { echo "Simulation FAILED"; exit 1; }
